//--- flist.f
+incdir+include
source/isaPkg.sv
source/corePkg.sv
source/controlFsm.sv
source/pcUnit.sv
source/regFile.sv
source/execUnit.sv
source/memPort.sv
source/cpuCore.sv
dv/cpuCoreTb.sv

//--- Makefile
SIM := obj_dir/cpuCoreSim
SOURCES := $(wildcard include/*.svh source/*.sv dv/*.sv) flist.f

.PHONY: run clean

$(SIM): $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cpuCoreTb \
		-Mdir obj_dir -o cpuCoreSim

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/cpuCoreTb.sv
`timescale 1ns/100ps
`include "cpuCore_cfg.svh"

module cpuCoreTb;
  import isaPkg::*;
  import corePkg::*;

  localparam logic [31:0] Seed = 32'h537f7417;
  localparam int   ClkPeriod = 100;
  localparam int   WatchdogNs = 40 * 64 * 40 * ClkPeriod;  // Programs x instrs x cycles
  localparam wordT Step = wordT'(`CPU_WORD_BYTES);
  localparam int   SpReg = `CPU_SP_REG;
  localparam int   FlagsReg = `CPU_FLAGS_REG;
  localparam wordT DumpBase = 32'h0001_0000;   // Register dump area
  localparam wordT MarkBase = 32'h0001_1000;   // Two marker words per jump
  localparam wordT StackBase = 32'h0002_0000;
  localparam wordT SubAddr = 32'h0000_0400;    // Subroutine of the stack test

  logic   clk, reset;
  logic   memReqValid, memReqReady, memRspValid, halted;
  memReqT memReq;
  memRspT memRsp;

  wordT        progMem [wordT];   // Program image of the current test
  wordT        dutMem [wordT];
  wordT        modelMem [wordT];
  wordT        progPtr;
  wordT        actAddr [$], actData [$], expAddr [$], expData [$];
  logic [31:0] progSeed, memSeed;  // Separate streams so both passes build equal programs
  int          readyPct, maxDelay, rspCount, errors, checks;
  wordT        rspData, firstAddr;
  logic        firstSeen, firstWrite;
  string       testName;

  cpuCore i_dut (
    .clk(clk), .reset(reset),
    .memReqValid(memReqValid), .memReqReady(memReqReady), .memReq(memReq),
    .memRspValid(memRspValid), .memRsp(memRsp), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcgStep(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned progRand(int unsigned n);
    progSeed = lcgStep(progSeed);
    return (progSeed >> 8) % n;   // Upper bits since low ones cycle fast
  endfunction

  function automatic wordT progWord();
    progSeed = lcgStep(progSeed);
    return progSeed;
  endfunction

  function automatic int unsigned memRand(int unsigned n);
    memSeed = lcgStep(memSeed);
    return (memSeed >> 8) % n;
  endfunction

  // Opcodes followed by a constant word
  function automatic logic carriesConst(opcodeE op);
    return op inside {MovRC, AddRRC, SubRRC, CmpRC, JmpC, JeC, JneC, JzRC, JnzRC,
                      MovRdC, MovdCR, MovdRoR};
  endfunction

  task automatic checkValue(string what, wordT expected, wordT actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Mismatch %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic appendWord(wordT w);
    progMem[progPtr] = w;
    progPtr += Step;
  endtask

  task automatic shortInstr(opcodeE op, int ra, int rb, int rc);
    appendWord({8'(rc), 8'(rb), 8'(ra), op});
  endtask

  task automatic longInstr(opcodeE op, int ra, int rb, wordT k);
    shortInstr(op, ra, rb, 0);
    appendWord(k);
  endtask

  task automatic dumpRegs();
    for (int i = 0; i < `CPU_REG_COUNT; i++)
      longInstr(MovdCR, 0, i, DumpBase + Step * i);
    shortInstr(Halt, 0, 0, 0);
  endtask

  // Memory model with one outstanding read, random ready and answer delay
  always @(negedge clk) begin
    memRspValid = 1'b0;
    if (reset) rspCount = 0;
    if (rspCount > 0) begin
      rspCount--;
      if (rspCount == 0) begin
        memRspValid  = 1'b1;
        memRsp.rdata = rspData;
      end
    end
    memReqReady = (memRand(100) < readyPct);
    if (!reset && memReqValid && memReqReady) begin   // Transfers on the next rising edge
      if (!firstSeen) begin
        firstSeen  = 1'b1;
        firstAddr  = memReq.addr;
        firstWrite = memReq.write;
      end
      if (memReq.write) begin
        dutMem[memReq.addr] = memReq.wdata;
        actAddr.push_back(memReq.addr);
        actData.push_back(memReq.wdata);
      end else begin
        rspData  = dutMem.exists(memReq.addr) ? dutMem[memReq.addr] : '0;
        rspCount = 1 + memRand(maxDelay);
      end
    end
  end

  function automatic wordT modelRead(wordT a);
    return modelMem.exists(a) ? modelMem[a] : '0;
  endfunction

  task automatic modelStore(wordT a, wordT d);
    modelMem[a] = d;
    expAddr.push_back(a);
    expData.push_back(d);
  endtask

  // Instruction-level reference for the ordered store stream
  task automatic predict();
    wordT   r [`CPU_REG_COUNT];
    wordT   ip, w, k, t, nextIp;
    int     ra, rb, rc, steps;
    logic   done;
    opcodeE op;
    for (int i = 0; i < `CPU_REG_COUNT; i++)
      r[i] = '0;
    ip    = wordT'(`CPU_RESET_IP);
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 4096) begin
      w  = modelRead(ip);
      k  = modelRead(ip + Step);
      op = opcodeE'(w[7:0]);
      ra = w[11:8];   // Low nibble of each register byte
      rb = w[19:16];
      rc = w[27:24];
      nextIp = carriesConst(op) ? ip + 2 * Step : ip + Step;
      steps++;
      case (op)
        MovRC:    r[ra] = k;
        MovRR:    r[ra] = r[rb];
        AddRRR:   r[ra] = r[rb] + r[rc];
        AddRRC:   r[ra] = r[rb] + k;
        SubRRR:   r[ra] = r[rb] - r[rc];
        SubRRC:   r[ra] = r[rb] - k;
        IncR:     r[ra] = r[ra] + 1;
        DecR:     r[ra] = r[ra] - 1;
        ShlRRR:   r[ra] = r[rb] << r[rc];
        ShrRRR:   r[ra] = r[rb] >> r[rc];
        NegRR:    r[ra] = '0 - r[rb];
        CmpRR:    r[FlagsReg] = wordT'({r[ra] > r[rb], r[ra] < r[rb], r[ra] == r[rb]});
        CmpRC:    r[FlagsReg] = wordT'({r[ra] > k, r[ra] < k, r[ra] == k});
        CmpERRR:  r[ra] = wordT'(r[rb] == r[rc]);
        CmpLtRRR: r[ra] = wordT'(r[rb] < r[rc]);
        JmpC:     nextIp = k;
        JeC:      if (r[FlagsReg][0]) nextIp = k;
        JneC:     if (!r[FlagsReg][0]) nextIp = k;
        JzRC:     if (r[ra] == '0) nextIp = k;
        JnzRC:    if (r[ra] != '0) nextIp = k;
        MovRdC:   r[ra] = modelRead(k);
        MovRdR:   r[ra] = modelRead(r[rb]);
        MovdCR:   modelStore(k, r[rb]);
        MovdRoR:  modelStore(k + r[ra], r[rb]);
        PushR: begin
          modelStore(r[SpReg], r[ra]);
          r[SpReg] += Step;
        end
        PopR: begin
          t        = r[SpReg];   // Stack move wins over a pop into r0
          r[ra]    = modelRead(t - Step);
          r[SpReg] = t - Step;
        end
        CallR: begin
          t = r[ra];
          modelStore(r[SpReg], ip + Step);
          r[SpReg] += Step;
          nextIp = t;
        end
        Ret: begin
          r[SpReg] -= Step;
          nextIp = modelRead(r[SpReg]) + Step;   // One word past the saved link
        end
        Halt:     done = 1'b1;
        default:  ;
      endcase
      ip = nextIp;
    end
    if (!done) begin
      errors++;
      $display("Reference model of %s did not reach Halt", testName);
    end
  endtask

  task automatic buildStraight();
    opcodeE aluOps [15] = '{MovRC, MovRR, AddRRR, AddRRC, SubRRR, SubRRC, IncR, DecR,
                            ShlRRR, ShrRRR, NegRR, CmpRR, CmpRC, CmpERRR, CmpLtRRR};
    opcodeE op;
    int     n;
    progMem.delete();
    progPtr = '0;
    for (int i = 2; i < `CPU_REG_COUNT; i++)
      longInstr(MovRC, i, 0, progRand(2) ? progWord() : wordT'(progRand(40)));  // Small shifts too
    n = 16 + progRand(9);
    for (int i = 0; i < n; i++) begin
      op = aluOps[progRand(15)];
      if (carriesConst(op))
        longInstr(op, progRand(16), progRand(16), progRand(2) ? progWord() : '0);
      else
        shortInstr(op, progRand(16), progRand(16), progRand(16));
    end
    dumpRegs();
  endtask

  task automatic buildBranch();
    opcodeE conds [5] = '{JeC, JneC, JzRC, JnzRC, JmpC};
    wordT   a, b, jumpAt;
    progMem.delete();
    progPtr = '0;
    a = progWord();
    b = progRand(2) ? a : progWord();
    longInstr(MovRC, 2, 0, a);
    longInstr(MovRC, 3, 0, b);
    for (int j = 0; j < 5; j++) begin
      if (progRand(2))
        shortInstr(CmpRR, 2, 3, 0);
      else
        longInstr(CmpRC, 2, 0, progRand(2) ? a : progWord());
      longInstr(MovRC, 4, 0, progRand(2) ? '0 : progWord());   // Zero test operand
      jumpAt = progPtr;
      longInstr(conds[j], 4, 0, jumpAt + 8 * Step);           // Past the fall-through block
      longInstr(MovRC, 5, 0, 32'h105e_0000 + j);
      longInstr(MovdCR, 0, 5, MarkBase + 2 * Step * j);
      longInstr(JmpC, 0, 0, jumpAt + 12 * Step);              // Join point
      longInstr(MovRC, 5, 0, 32'h7a4e_0000 + j);
      longInstr(MovdCR, 0, 5, MarkBase + 2 * Step * j + Step);
    end
    shortInstr(Halt, 0, 0, 0);
  endtask

  task automatic buildStack();
    int pushes, pops;
    progMem.delete();
    progPtr = '0;
    longInstr(MovRC, SpReg, 0, StackBase);
    for (int i = 2; i < 10; i++)
      longInstr(MovRC, i, 0, progWord());
    longInstr(MovRC, 10, 0, SubAddr);
    pushes = 1 + progRand(4);
    pops   = progRand(pushes + 1);
    for (int i = 0; i < pushes; i++)
      shortInstr(PushR, 2 + progRand(8), 0, 0);
    for (int i = 0; i < pops; i++)
      shortInstr(PopR, 2 + progRand(8), 0, 0);
    longInstr(MovRdC, 14, 0, StackBase);   // Oldest stack slot
    shortInstr(CallR, 10, 0, 0);
    shortInstr(IncR, 15, 0, 0);            // Skipped since return lands one word later
    longInstr(MovdRoR, SpReg, 2 + progRand(8), 32'h40);
    shortInstr(MovRdR, 11, SpReg, 0);      // Link left just above the stack top
    dumpRegs();
    progPtr = SubAddr;
    shortInstr(IncR, 12, 0, 0);
    shortInstr(PushR, 12, 0, 0);
    shortInstr(PopR, 13, 0, 0);
    shortInstr(Ret, 0, 0, 0);
  endtask

  task automatic runProgram(string name);
    int n;
    testName = name;
    dutMem   = progMem;
    modelMem = progMem;
    actAddr.delete();
    actData.delete();
    expAddr.delete();
    expData.delete();
    predict();
    reset     = 1'b1;
    firstSeen = 1'b0;
    repeat (3) @(negedge clk);
    checkValue("valid after reset", '0, wordT'(memReqValid));
    checkValue("halted after reset", '0, wordT'(halted));
    reset = 1'b0;
    while (!halted) @(negedge clk);       // Run until Halt
    checkValue("first request address", '0, firstAddr);
    checkValue("first request write", '0, wordT'(firstWrite));
    checkValue("store count", wordT'(expAddr.size()), wordT'(actAddr.size()));
    n = (expAddr.size() < actAddr.size()) ? expAddr.size() : actAddr.size();
    for (int i = 0; i < n; i++) begin
      checkValue($sformatf("store %0d address", i), expAddr[i], actAddr[i]);
      checkValue($sformatf("store %0d data", i), expData[i], actData[i]);
    end
    repeat (50) begin                     // Parked core stays quiet
      @(negedge clk);
      checkValue("halted held", 1, wordT'(halted));
      checkValue("request after halt", '0, wordT'(memReqValid));
    end
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    reset       = 1'b1;
    memReqReady = 1'b0;
    memRspValid = 1'b0;
    memRsp      = '0;
    rspCount    = 0;
    rspData     = '0;
    firstSeen   = 1'b0;
    firstAddr   = '0;
    firstWrite  = 1'b0;
    memSeed     = ~Seed;
    readyPct    = 80;
    maxDelay    = 4;
    @(negedge clk);
    for (int pass = 0; pass < 2; pass++) begin
      progSeed = Seed;                    // Same programs in both passes
      readyPct = pass ? 25 : 80;          // Second pass under heavy back-pressure
      maxDelay = pass ? 4 : 2;
      for (int t = 0; t < 6; t++) begin
        buildStraight();
        runProgram($sformatf("straight %0d pass %0d", t, pass));
      end
      for (int t = 0; t < 6; t++) begin
        buildBranch();
        runProgram($sformatf("branch %0d pass %0d", t, pass));
      end
      for (int t = 0; t < 4; t++) begin
        buildStack();
        runProgram($sformatf("stack %0d pass %0d", t, pass));
      end
    end
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: %s did not reach Halt in time", testName);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- source/cpuCore.sv
`timescale 1ns/100ps

module cpuCore (
  input  logic            clk,
  input  logic            reset,
  output logic            memReqValid,
  input  logic            memReqReady,
  output corePkg::memReqT memReq,
  input  logic            memRspValid,
  input  corePkg::memRspT memRsp,
  output logic            halted
);
  import corePkg::*;
  import isaPkg::*;

  accessE     access;
  logic       accessStart;
  logic       accessDone;
  instrT      instr;        // Current instruction register
  wordT       constWord;    // Second word of long opcodes
  wordT       rdata;        // Last read data from memory
  wordT       ip;
  wordT       regA, regB, regC;
  wordT       sp;
  wordT       result;
  logic       regWrite, spUpdate, pcUpdate;
  logic       flagZero;
  logic       flagsWrite;
  logic [2:0] flags;
  logic       takeBranch;

  controlFsm i_fsm (
    .clk(clk), .reset(reset),
    .memRdata(rdata), .accessDone(accessDone),
    .access(access), .accessStart(accessStart),
    .instr(instr), .constWord(constWord),
    .regWrite(regWrite), .spUpdate(spUpdate), .pcUpdate(pcUpdate),
    .halted(halted)
  );

  pcUnit i_pc (
    .clk(clk), .reset(reset), .pcUpdate(pcUpdate),
    .instr(instr), .constWord(constWord), .takeBranch(takeBranch),
    .regA(regA), .loadData(rdata), .ip(ip)
  );

  regFile i_regs (
    .clk(clk), .reset(reset), .instr(instr),
    .regA(regA), .regB(regB), .regC(regC), .sp(sp), .flagZero(flagZero),
    .regWrite(regWrite), .wrData(result),
    .flagsWrite(flagsWrite), .flags(flags), .spUpdate(spUpdate)
  );

  execUnit i_exec (
    .instr(instr), .regA(regA), .regB(regB), .regC(regC),
    .constWord(constWord), .loadData(rdata), .flagEqual(flagZero),
    .result(result), .flagsWrite(flagsWrite), .flags(flags),
    .takeBranch(takeBranch), .ipNext(ip)
  );

  memPort i_mem (
    .clk(clk), .reset(reset), .access(access), .accessStart(accessStart),
    .instr(instr), .ip(ip), .constWord(constWord),
    .regA(regA), .regB(regB), .sp(sp),
    .memReqValid(memReqValid), .memReqReady(memReqReady), .memReq(memReq),
    .memRspValid(memRspValid), .memRsp(memRsp),
    .rdata(rdata), .accessDone(accessDone)
  );

endmodule

//--- source/memPort.sv
`timescale 1ns/100ps
`include "cpuCore_cfg.svh"

module memPort (
  input  logic            clk,
  input  logic            reset,
  input  corePkg::accessE access,
  input  logic            accessStart,
  input  isaPkg::instrT   instr,
  input  corePkg::wordT   ip,
  input  corePkg::wordT   constWord,
  input  corePkg::wordT   regA,
  input  corePkg::wordT   regB,
  input  corePkg::wordT   sp,
  output logic            memReqValid,
  input  logic            memReqReady,
  output corePkg::memReqT memReq,
  input  logic            memRspValid,
  input  corePkg::memRspT memRsp,
  output corePkg::wordT   rdata,
  output logic            accessDone
);
  import isaPkg::*;
  import corePkg::*;

  localparam wordT Step = wordT'(`CPU_WORD_BYTES);

  memReqT reqNext;
  logic   waitRsp;      // Read transferred, answer pending
  logic   rspHit;
  wordT   rdataQ;

  always_comb begin
    reqNext.addr  = ip;
    reqNext.wdata = '0;
    reqNext.write = (access == AccStore);
    case (access)
      AccConst: reqNext.addr = ip + Step;
      AccLoad: begin
        case (instr.op)
          MovRdC:  reqNext.addr = constWord;
          MovRdR:  reqNext.addr = regB;
          default: reqNext.addr = sp - Step;    // Pop and return
        endcase
      end
      AccStore: begin
        case (instr.op)
          MovdCR:  {reqNext.addr, reqNext.wdata} = {constWord, regB};
          MovdRoR: {reqNext.addr, reqNext.wdata} = {constWord + regA, regB};
          PushR:   {reqNext.addr, reqNext.wdata} = {sp, regA};
          default: {reqNext.addr, reqNext.wdata} = {sp, ip + Step};  // Call link
        endcase
      end
      default: reqNext.addr = ip;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      memReqValid <= 1'b0;
      waitRsp     <= 1'b0;
    end else begin
      if (accessStart)
        memReqValid <= 1'b1;
      else if (memReqReady)
        memReqValid <= 1'b0;
      if (memReqValid && memReqReady && !memReq.write)
        waitRsp <= 1'b1;
      else if (memRspValid)
        waitRsp <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accessStart) memReq <= reqNext;
    if (rspHit) rdataQ <= memRsp.rdata;
  end

  assign rspHit     = waitRsp && memRspValid;
  assign accessDone = rspHit || (memReqValid && memReqReady && memReq.write);
  assign rdata      = rspHit ? memRsp.rdata : rdataQ;   // Bypass on arrival

  reqStable: assert property (@(posedge clk) disable iff (reset)
    memReqValid && !memReqReady |=> memReqValid && $stable(memReq));

  // Sequencer only starts once the last access has finished
  startWhenIdle: assert property (@(posedge clk) disable iff (reset)
    accessStart |-> !memReqValid && !waitRsp);

endmodule

//--- source/execUnit.sv
`timescale 1ns/100ps
`include "cpuCore_cfg.svh"

module execUnit (
  input  isaPkg::instrT instr,
  input  corePkg::wordT regA,
  input  corePkg::wordT regB,
  input  corePkg::wordT regC,
  input  corePkg::wordT constWord,
  input  corePkg::wordT loadData,
  input  logic          flagEqual,
  output corePkg::wordT result,
  output logic          flagsWrite,
  output logic [2:0]    flags,
  output logic          takeBranch,
  input  corePkg::wordT ipNext
);
  import isaPkg::*;
  import corePkg::*;

  localparam wordT Step = wordT'(`CPU_WORD_BYTES);

  aluOpE aluOp;
  wordT  opB;           // rc or constant for add and sub
  wordT  cmpB;          // Second compare operand

  always_comb begin
    case (instr.op)
      MovRC:                 aluOp = AluConst;
      MovRR:                 aluOp = AluMovB;
      AddRRR, AddRRC:        aluOp = AluAdd;
      SubRRR, SubRRC:        aluOp = AluSub;
      IncR:                  aluOp = AluInc;
      DecR:                  aluOp = AluDec;
      ShlRRR:                aluOp = AluShl;
      ShrRRR:                aluOp = AluShr;
      NegRR:                 aluOp = AluNeg;
      CmpERRR:               aluOp = AluCmpEq;
      CmpLtRRR:              aluOp = AluCmpLt;
      MovRdC, MovRdR, PopR:  aluOp = AluLoad;
      CallR:                 aluOp = AluLink;
      default:               aluOp = AluNone;
    endcase
  end

  assign opB = isLongOp(instr.op) ? constWord : regC;

  always_comb begin
    case (aluOp)
      AluAdd:   result = regB + opB;
      AluSub:   result = regB - opB;
      AluInc:   result = regA + wordT'(1);
      AluDec:   result = regA - wordT'(1);
      AluShl:   result = regB << regC;
      AluShr:   result = regB >> regC;
      AluNeg:   result = -regB;
      AluCmpEq: result = wordT'(regB == regC);
      AluCmpLt: result = wordT'(regB < regC);    // Unsigned
      AluMovB:  result = regB;
      AluConst: result = constWord;
      AluLoad:  result = loadData;
      AluLink:  result = ipNext + Step;          // Same link value the call pushes
      default:  result = '0;
    endcase
  end

  // Flags as {greater, less, equal}, unsigned
  assign cmpB       = (instr.op == CmpRC) ? constWord : regB;
  assign flags      = {regA > cmpB, regA < cmpB, regA == cmpB};
  assign flagsWrite = instr.op inside {CmpRR, CmpRC};

  always_comb begin
    case (instr.op)
      JeC:     takeBranch = flagEqual;
      JneC:    takeBranch = !flagEqual;
      JzRC:    takeBranch = (regA == '0);
      JnzRC:   takeBranch = (regA != '0);
      default: takeBranch = 1'b0;
    endcase
  end

endmodule

//--- source/regFile.sv
`timescale 1ns/100ps
`include "cpuCore_cfg.svh"

module regFile (
  input  logic          clk,
  input  logic          reset,
  input  isaPkg::instrT instr,
  output corePkg::wordT regA,
  output corePkg::wordT regB,
  output corePkg::wordT regC,
  output corePkg::wordT sp,
  output logic          flagZero,
  input  logic          regWrite,
  input  corePkg::wordT wrData,
  input  logic          flagsWrite,
  input  logic [2:0]    flags,
  input  logic          spUpdate
);
  import isaPkg::*;
  import corePkg::*;

  localparam wordT Step = wordT'(`CPU_WORD_BYTES);

  wordT                     regs [`CPU_REG_COUNT];
  logic [`CPU_REG_BITS-1:0] idxA, idxB, idxC;
  logic                     spDown;       // Pop and return shrink the stack

  assign idxA = instr.ra[`CPU_REG_BITS-1:0];
  assign idxB = instr.rb[`CPU_REG_BITS-1:0];
  assign idxC = instr.rc[`CPU_REG_BITS-1:0];

  assign regA     = regs[idxA];
  assign regB     = regs[idxB];
  assign regC     = regs[idxC];
  assign sp       = regs[`CPU_SP_REG];
  assign flagZero = regs[`CPU_FLAGS_REG][0];  // Equal flag
  assign spDown   = instr.op inside {PopR, Ret};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++)
        regs[i] <= '0;
    end else begin
      if (regWrite && flagsWrite)
        regs[`CPU_FLAGS_REG] <= {{(`CPU_DATA_WIDTH-3){1'b0}}, flags};
      else if (regWrite)
        regs[idxA] <= wrData;
      // Stack pointer move wins over a pop into r0
      if (spUpdate)
        regs[`CPU_SP_REG] <= spDown ? sp - Step : sp + Step;
    end
  end

  // Decoder upstream must hand over a valid destination
  destInRange: assert property (@(posedge clk) disable iff (reset)
    regWrite && !flagsWrite |-> instr.ra < `CPU_REG_COUNT);

endmodule

//--- source/pcUnit.sv
`timescale 1ns/100ps
`include "cpuCore_cfg.svh"

module pcUnit (
  input  logic          clk,
  input  logic          reset,
  input  logic          pcUpdate,
  input  isaPkg::instrT instr,
  input  corePkg::wordT constWord,
  input  logic          takeBranch,
  input  corePkg::wordT regA,
  input  corePkg::wordT loadData,
  output corePkg::wordT ip
);
  import isaPkg::*;
  import corePkg::*;

  localparam wordT Step = wordT'(`CPU_WORD_BYTES);

  wordT nextIp;

  always_comb begin
    case (instr.op)
      Halt:    nextIp = ip;                 // Parked
      JmpC:    nextIp = constWord;
      CallR:   nextIp = regA;
      Ret:     nextIp = loadData + Step;    // Past the saved link
      default: begin
        if (takeBranch)
          nextIp = constWord;
        else
          nextIp = isLongOp(instr.op) ? ip + Step + Step : ip + Step;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ip <= wordT'(`CPU_RESET_IP);
    else if (pcUpdate)
      ip <= nextIp;
  end

endmodule

//--- source/controlFsm.sv
`timescale 1ns/100ps

module controlFsm (
  input  logic            clk,
  input  logic            reset,
  input  corePkg::wordT   memRdata,
  input  logic            accessDone,
  output corePkg::accessE access,
  output logic            accessStart,
  output isaPkg::instrT   instr,
  output corePkg::wordT   constWord,
  output logic            regWrite,
  output logic            spUpdate,
  output logic            pcUpdate,
  output logic            halted
);
  import isaPkg::*;
  import corePkg::*;

  ctrlStateE state, nextState;
  instrT     fetched;       // Instruction word as it arrives

  assign fetched = instrT'(memRdata);

  function automatic logic isLoad(opcodeE op);
    return op inside {MovRdC, MovRdR, PopR, Ret};
  endfunction

  function automatic logic isStore(opcodeE op);
    return op inside {MovdCR, MovdRoR, PushR, CallR};
  endfunction

  // Commit strobe for register writes and flag compares
  function automatic logic commitsReg(opcodeE op);
    return op inside {MovRC, MovRR, AddRRR, AddRRC, SubRRR, SubRRC, IncR, DecR, ShlRRR,
                      ShrRRR, NegRR, CmpRR, CmpRC, CmpERRR, CmpLtRRR, MovRdC, MovRdR, PopR};
  endfunction

  always_comb begin
    nextState = state;
    case (state)
      Fetch:     nextState = FetchWait;
      FetchWait: if (accessDone) nextState = isLongOp(fetched.op) ? ConstReq : ReadRegs;
      ReadRegs:  nextState = (isLoad(instr.op) || isStore(instr.op)) ? DataReq : Execute;
      ConstReq:  nextState = ConstWait;
      ConstWait: begin
        if (accessDone)
          nextState = (isLoad(instr.op) || isStore(instr.op)) ? DataReq : Execute;
      end
      DataReq:   nextState = DataWait;
      DataWait:  if (accessDone) nextState = Execute;
      Execute:   nextState = (instr.op == Halt) ? Halted : Fetch;
      default:   nextState = Halted;  // Stuck until reset
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state  <= Fetch;
      halted <= 1'b0;
    end else begin
      state <= nextState;
      if (state == Execute && instr.op == Halt) halted <= 1'b1;
    end
  end

  // Instruction and constant registers
  always_ff @(posedge clk) begin
    if (state == FetchWait && accessDone) instr <= fetched;
    if (state == ConstWait && accessDone) constWord <= memRdata;
  end

  always_comb begin
    case (state)
      ConstReq, ConstWait: access = AccConst;
      DataReq, DataWait:   access = isLoad(instr.op) ? AccLoad : AccStore;
      default:             access = AccFetch;
    endcase
  end

  assign accessStart = state inside {Fetch, ConstReq, DataReq};
  assign pcUpdate    = (state == Execute);
  assign regWrite    = (state == Execute) && commitsReg(instr.op);
  assign spUpdate    = (state == Execute) && (instr.op inside {PushR, PopR, CallR, Ret});

  // Port completes an access only while the sequencer waits for it
  doneInWait: assert property (@(posedge clk) disable iff (reset)
    accessDone |-> state inside {FetchWait, ConstWait, DataWait});

  // Parked core starts no access and holds its pointer
  haltQuiet: assert property (@(posedge clk) disable iff (reset)
    halted |-> !accessStart && !pcUpdate);

endmodule

//--- source/corePkg.sv
`include "cpuCore_cfg.svh"

package corePkg;

  typedef logic [`CPU_DATA_WIDTH-1:0] wordT;

  // Sequencer states, one instruction at a time
  typedef enum logic [3:0] {
    Fetch,
    FetchWait,
    ReadRegs,
    ConstReq,
    ConstWait,
    DataReq,
    DataWait,
    Execute,
    Halted
  } ctrlStateE;

  // What the memory port is asked to do
  typedef enum logic [1:0] {
    AccFetch,
    AccConst,
    AccLoad,
    AccStore
  } accessE;

  typedef struct packed {
    wordT addr;
    wordT wdata;
    logic write;    // Low for reads
  } memReqT;

  typedef struct packed {
    wordT rdata;
  } memRspT;

  // Result selection in the ALU
  typedef enum logic [3:0] {
    AluNone,
    AluAdd,
    AluSub,
    AluInc,
    AluDec,
    AluShl,
    AluShr,
    AluNeg,
    AluCmpEq,
    AluCmpLt,
    AluMovB,
    AluConst,
    AluLoad,
    AluLink
  } aluOpE;

endpackage

//--- source/isaPkg.sv
package isaPkg;

  // One byte opcode, values counted up from zero
  typedef enum logic [7:0] {
    Nop,
    MovRC,
    MovRR,
    AddRRR,
    AddRRC,
    SubRRR,
    SubRRC,
    IncR,
    DecR,
    ShlRRR,
    ShrRRR,
    NegRR,
    CmpRR,      // Sets flags from ra and rb
    CmpRC,      // Sets flags from ra and constant
    CmpERRR,
    CmpLtRRR,
    JmpC,
    JeC,
    JneC,
    JzRC,
    JnzRC,
    MovRdC,     // Load from constant address
    MovRdR,     // Load from address in rb
    MovdCR,     // Store rb to constant address
    MovdRoR,    // Store rb to ra plus constant
    PushR,
    PopR,
    CallR,
    Ret,
    Halt
  } opcodeE;

  // Instruction word, opcode in the low byte
  typedef struct packed {
    logic [7:0] rc;
    logic [7:0] rb;
    logic [7:0] ra;
    opcodeE     op;
  } instrT;

  // Opcodes followed by a constant word
  function automatic logic isLongOp(opcodeE op);
    return op inside {MovRC, AddRRC, SubRRC, CmpRC, JmpC, JeC, JneC, JzRC, JnzRC,
                      MovRdC, MovdCR, MovdRoR};
  endfunction

endpackage

//--- include/cpuCore_cfg.svh
`ifndef CPU_CORE_CFG_SVH
`define CPU_CORE_CFG_SVH

// Datapath and address width, one word
`define CPU_DATA_WIDTH 32

// Register file shape
`define CPU_REG_COUNT 16
`define CPU_REG_BITS  4

// Fixed register roles
`define CPU_SP_REG    0   // Stack pointer
`define CPU_FLAGS_REG 1   // Bit 0 equal, bit 1 less, bit 2 greater

// First fetch address after reset
`define CPU_RESET_IP 0

// Byte step between words
`define CPU_WORD_BYTES 4

`endif
